// File: project.f
isa_pkg.sv
mem_pkg.sv
dmem_if.sv
lane_ram.sv
data_mem.sv
instr_mem.sv
mem_top.sv
mem_top_asserts.sv
tb_mem_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_mem_top -f project.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_mem_top 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "RESULT: PASS"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tb_mem_top.sv
`timescale 1ns/10ps

module tb_mem_top;

	localparam int n_idle  = 4;
	localparam int n_fetch = 400;
	localparam int n_word  = 200;
	localparam int n_sub   = 300;
	localparam int n_ext   = 300;
	localparam int n_mix   = 600;
	localparam int n_tail  = 8;
	localparam int test_cycles = 3 + n_idle + mem_pkg::imem_words + mem_pkg::dmem_words
		+ n_fetch + 2 * n_word + 2 * n_sub + n_ext + n_mix + n_tail;
	localparam int cycle_limit = 2 * test_cycles + 100;
	localparam int dtop = mem_pkg::dmem_aw + 1; // highest data byte address bit
	localparam int itop = mem_pkg::imem_aw + 1;

	logic        clk;
	logic        reset;
	logic        fetch;
	logic [31:0] fetch_addr;
	logic        load_we;
	logic [31:0] load_addr;
	logic [31:0] load_data;
	logic [31:0] instr;
	logic        instr_valid;
	logic        halt;
	logic [31:0] d_addr;
	logic [2:0]  d_op;
	logic        d_rd;
	logic        d_we;
	logic [31:0] d_wdata;
	logic [31:0] d_rdata;
	logic        d_rvalid;

	logic [7:0]  dmem_model [mem_pkg::dmem_words*4]; // byte addressed
	logic [31:0] imem_model [mem_pkg::imem_words];

	// responses due one cycle after the request now on the inputs
	logic        pend_load;
	logic [31:0] pend_rdata;
	logic        pend_fetch;
	logic [31:0] pend_instr;
	logic        pend_halt;

	int errors = 0;
	int checks = 0;
	int cycle_count = 0;

	mem_top dut0 (
		.clk         (clk),
		.reset       (reset),
		.fetch       (fetch),
		.fetch_addr  (fetch_addr),
		.load_we     (load_we),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.instr       (instr),
		.instr_valid (instr_valid),
		.halt        (halt),
		.d_addr      (d_addr),
		.d_op        (d_op),
		.d_rd        (d_rd),
		.d_we        (d_we),
		.d_wdata     (d_wdata),
		.d_rdata     (d_rdata),
		.d_rvalid    (d_rvalid)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("MISMATCH at %0t: %s actual %h expected %h", $time, name, actual, expected);
		end
	endtask

	// expected load result from the byte model
	function automatic logic [31:0] model_load(input logic [31:0] addr, input logic [2:0] op);
		logic [7:0]  b;
		logic [15:0] h;
		logic [31:0] w;
		b = dmem_model[addr[dtop:0]];
		h = {dmem_model[{addr[dtop:1], 1'b1}], dmem_model[{addr[dtop:1], 1'b0}]};
		w = {dmem_model[{addr[dtop:2], 2'b11}], dmem_model[{addr[dtop:2], 2'b10}],
			dmem_model[{addr[dtop:2], 2'b01}], dmem_model[{addr[dtop:2], 2'b00}]};
		case (op)
			3'b000:  return {{24{b[7]}}, b}; // lb
			3'b001:  return {{16{h[15]}}, h}; // lh
			3'b100:  return {24'b0, b}; // lbu
			3'b101:  return {16'b0, h}; // lhu
			default: return w; // lw and undefined codes
		endcase
	endfunction

	task automatic model_store(input logic [31:0] addr, input logic [2:0] op,
		input logic [31:0] wdata);
		case (op)
			3'b000: dmem_model[addr[dtop:0]] = wdata[7:0];
			3'b001:
			begin
				dmem_model[{addr[dtop:1], 1'b0}] = wdata[7:0];
				dmem_model[{addr[dtop:1], 1'b1}] = wdata[15:8];
			end
			3'b010:
			begin
				dmem_model[{addr[dtop:2], 2'b00}] = wdata[7:0];
				dmem_model[{addr[dtop:2], 2'b01}] = wdata[15:8];
				dmem_model[{addr[dtop:2], 2'b10}] = wdata[23:16];
				dmem_model[{addr[dtop:2], 2'b11}] = wdata[31:24];
			end
			default: ; // other codes store nothing
		endcase
	endtask

	task automatic set_data(input logic rd, input logic we, input logic [31:0] addr,
		input logic [2:0] op, input logic [31:0] wdata);
		d_rd    = rd;
		d_we    = we;
		d_addr  = addr;
		d_op    = op;
		d_wdata = wdata;
		if (we)
			model_store(addr, op, wdata); // store wins, no load
		else if (rd)
		begin
			pend_load  = 1'b1;
			pend_rdata = model_load(addr, op);
		end
	endtask

	task automatic set_fetch(input logic [31:0] addr);
		fetch      = 1'b1;
		fetch_addr = addr;
		pend_fetch = 1'b1;
		pend_instr = imem_model[addr[itop:2]];
		pend_halt  = (pend_instr == isa_pkg::halt_word);
	endtask

	task automatic set_iload(input logic [31:0] addr, input logic [31:0] data);
		load_we   = 1'b1;
		load_addr = addr;
		load_data = data;
		imem_model[addr[itop:2]] = data;
	endtask

	// one clock, then check what the last request owes
	task automatic step();
		@(posedge clk);
		#1;
		check("d_rvalid", 32'(d_rvalid), 32'(pend_load));
		if (pend_load)
			check("d_rdata", d_rdata, pend_rdata);
		check("instr_valid", 32'(instr_valid), 32'(pend_fetch));
		if (pend_fetch)
			check("instr", instr, pend_instr);
		check("halt", 32'(halt), 32'(pend_fetch && pend_halt));
		pend_load  = 1'b0;
		pend_fetch = 1'b0;
		pend_halt  = 1'b0;
		d_rd       = 1'b0;
		d_we       = 1'b0;
		fetch      = 1'b0;
		load_we    = 1'b0;
	endtask

	// random byte address inside the first window words, junk in unused bits
	function automatic logic [31:0] daddr(input int window);
		logic [31:0] r;
		int idx;
		r   = $urandom();
		idx = int'($urandom_range(0, window - 1));
		return {r[31:dtop+1], idx[mem_pkg::dmem_aw-1:0], r[1:0]};
	endfunction

	function automatic logic [31:0] iaddr(input int idx);
		logic [31:0] r;
		r = $urandom();
		return {r[31:itop+1], idx[mem_pkg::imem_aw-1:0], r[1:0]};
	endfunction

	initial
	begin
		logic [31:0] r;
		logic [31:0] a;
		logic [2:0]  op;
		int idx;
		int halt_idx;
		r = $urandom(32'ha67b9bb0); // seed once
		reset      = 1'b1;
		fetch      = 1'b0;
		fetch_addr = 32'h0;
		load_we    = 1'b0;
		load_addr  = 32'h0;
		load_data  = 32'h0;
		d_addr     = 32'h0;
		d_op       = 3'b000;
		d_rd       = 1'b0;
		d_we       = 1'b0;
		d_wdata    = 32'h0;
		pend_load  = 1'b0;
		pend_rdata = 32'h0;
		pend_fetch = 1'b0;
		pend_instr = 32'h0;
		pend_halt  = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		repeat (n_idle) step(); // outputs stay low without requests

		for (int i = 0; i < mem_pkg::imem_words; i++)
		begin
			r = $urandom();
			if (r == isa_pkg::halt_word)
				r = ~r;
			set_iload(32'(i * 4), r);
			step();
		end
		halt_idx = int'($urandom_range(0, mem_pkg::imem_words - 1));
		set_iload(32'(halt_idx * 4), isa_pkg::halt_word);
		step();

		for (int i = 0; i < mem_pkg::dmem_words; i++)
		begin
			set_data(1'b0, 1'b1, 32'(i * 4), 3'b010, $urandom());
			step();
		end

		// fetches, every eighth one hits the halt word
		for (int i = 0; i < n_fetch; i++)
		begin
			idx = (i % 8 == 0) ? halt_idx : int'($urandom_range(0, mem_pkg::imem_words - 1));
			a = iaddr(idx);
			set_fetch(a);
			if (i % 16 == 5 && idx != halt_idx)
				set_iload(a, $urandom()); // same-edge write, fetch sees old word
			step();
		end

		for (int i = 0; i < n_word; i++)
		begin
			a = daddr(mem_pkg::dmem_words);
			set_data(1'b0, 1'b1, a, 3'b010, $urandom());
			step();
			set_data(1'b1, 1'b0, a, 3'b010, 32'h0);
			step();
		end

		// sb or sh, then read back the merged word
		for (int i = 0; i < n_sub; i++)
		begin
			a  = daddr(mem_pkg::dmem_words);
			r  = $urandom();
			op = r[0] ? 3'b001 : 3'b000;
			set_data(1'b0, 1'b1, a, op, $urandom());
			step();
			set_data(1'b1, 1'b0, a, 3'b010, 32'h0);
			step();
		end

		for (int i = 0; i < n_ext; i++)
		begin
			a = daddr(mem_pkg::dmem_words);
			r = $urandom();
			set_data(1'b1, 1'b0, a, r[2:0], 32'h0); // all eight codes
			step();
		end

		// back to back traffic in a small window so loads hit fresh stores
		for (int i = 0; i < n_mix; i++)
		begin
			a = daddr(16);
			r = $urandom();
			set_data(r[0], r[1], a, r[4:2], $urandom());
			step();
		end

		repeat (2) step();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: mem_top_asserts.sv
`timescale 1ns/10ps

module mem_top_asserts (
	input logic        clk,
	input logic        reset,
	input logic        d_rd,
	input logic        d_we,
	input logic        d_rvalid,
	input logic [31:0] instr,
	input logic        instr_valid,
	input logic        halt
);

	// a load is accepted when rd is high and no store shares its edge
	property rvalid_follows_load;
		@(posedge clk) disable iff (reset)
			d_rvalid == $past(d_rd && !d_we && !reset);
	endproperty

	property quiet_after_reset;
		@(posedge clk) $past(reset) && !reset |-> !d_rvalid && !instr_valid;
	endproperty

	// halt comes from the compare path, instr from the fetch register
	property halt_with_valid;
		@(posedge clk) disable iff (reset)
			halt == (instr_valid && instr == isa_pkg::halt_word);
	endproperty

	a_rvalid: assert property (rvalid_follows_load)
		else $error("d_rvalid is not one cycle after an accepted load");

	a_reset: assert property (quiet_after_reset)
		else $error("d_rvalid or instr_valid high in the cycle after reset");

	a_halt: assert property (halt_with_valid)
		else $error("halt does not match a valid fetch of the halt word");

endmodule

bind mem_top mem_top_asserts asserts0 (
	.clk         (clk),
	.reset       (reset),
	.d_rd        (d_rd),
	.d_we        (d_we),
	.d_rvalid    (d_rvalid),
	.instr       (instr),
	.instr_valid (instr_valid),
	.halt        (halt)
);

// File: mem_top.sv
`timescale 1ns/10ps

module mem_top (
	input  logic        clk,
	input  logic        reset,

	// instruction side
	input  logic        fetch,
	input  logic [31:0] fetch_addr,  // byte address
	input  logic        load_we,
	input  logic [31:0] load_addr,   // byte address
	input  logic [31:0] load_data,
	output logic [31:0] instr,
	output logic        instr_valid,
	output logic        halt,

	// data side
	input  logic [31:0] d_addr,
	input  logic [2:0]  d_op,        // funct3 width code
	input  logic        d_rd,
	input  logic        d_we,
	input  logic [31:0] d_wdata,
	output logic [31:0] d_rdata,
	output logic        d_rvalid
);

	dmem_if dbus ();

	// the ports stand in for the core side of the data bus
	assign dbus.addr  = d_addr;
	assign dbus.op    = d_op;
	assign dbus.rd    = d_rd;
	assign dbus.we    = d_we;
	assign dbus.wdata = d_wdata;
	assign d_rdata    = dbus.rdata;
	assign d_rvalid   = dbus.rvalid;

	instr_mem imem0 (
		.clk         (clk),
		.reset       (reset),
		.fetch       (fetch),
		.fetch_addr  (fetch_addr[mem_pkg::imem_aw+1:2]), // word index
		.load_we     (load_we),
		.load_addr   (load_addr[mem_pkg::imem_aw+1:2]),
		.load_data   (load_data),
		.instr       (instr),
		.instr_valid (instr_valid),
		.halt        (halt)
	);

	data_mem dmem0 (
		.clk   (clk),
		.reset (reset),
		.bus   (dbus.memory)
	);

endmodule

// File: instr_mem.sv
`timescale 1ns/10ps

module instr_mem (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        fetch,
	input  logic [mem_pkg::imem_aw-1:0] fetch_addr,
	input  logic                        load_we,
	input  logic [mem_pkg::imem_aw-1:0] load_addr,
	input  logic [isa_pkg::ilen-1:0]    load_data,
	output logic [isa_pkg::ilen-1:0]    instr,
	output logic                        instr_valid,
	output logic                        halt
);

	logic [isa_pkg::ilen-1:0] mem [mem_pkg::imem_words];

	// program load, one word per cycle
	always_ff @(posedge clk)
	begin
		if (load_we)
			mem[load_addr] <= load_data;
	end

	// fetch reads the word before a load on the same edge
	always_ff @(posedge clk)
	begin
		if (fetch)
			instr <= mem[fetch_addr];
	end

	// halt is compared before the register so it lines up with instr_valid
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			instr_valid <= 1'b0;
			halt        <= 1'b0;
		end
		else
		begin
			instr_valid <= fetch;
			halt        <= fetch && (mem[fetch_addr] == isa_pkg::halt_word);
		end
	end

endmodule

// File: data_mem.sv
`timescale 1ns/10ps

module data_mem (
	input logic    clk,
	input logic    reset,
	dmem_if.memory bus
);

	logic [mem_pkg::dmem_aw-1:0] word_addr;
	logic [1:0]                  byte_off;
	logic                        load_go;
	mem_pkg::lane_mask_t         lane_we;
	logic [isa_pkg::xlen-1:0]    store_data;
	mem_pkg::mem_word_u          rword;
	isa_pkg::mem_op_t            op_q;
	logic [1:0]                  off_q;
	logic                        valid_q;
	logic [7:0]                  byte_sel;
	logic [15:0]                 half_sel;
	logic [isa_pkg::xlen-1:0]    load_data;

	assign word_addr = bus.addr[mem_pkg::dmem_aw+1:2];
	assign byte_off  = bus.addr[1:0];
	assign load_go   = bus.rd & ~bus.we; // a store wins over a load

	// lane enables for the store
	always_comb
	begin
		lane_we = 4'b0000;
		if (bus.we)
		begin
			case (bus.op)
				isa_pkg::op_byte: lane_we[byte_off] = 1'b1;
				isa_pkg::op_half: lane_we = byte_off[1] ? 4'b1100 : 4'b0011;
				isa_pkg::op_word: lane_we = 4'b1111;
				default:          lane_we = 4'b0000; // no write
			endcase
		end
	end

	// copy the low byte or halfword onto every lane, the mask picks one
	always_comb
	begin
		case (bus.op)
			isa_pkg::op_byte: store_data = {4{bus.wdata[7:0]}};
			isa_pkg::op_half: store_data = {2{bus.wdata[15:0]}};
			default:          store_data = bus.wdata;
		endcase
	end

	lane_ram ram0 (
		.clk     (clk),
		.addr    (word_addr),
		.rd      (load_go),
		.lane_we (lane_we),
		.wdata   (store_data),
		.rword   (rword)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= load_go;
	end

	// width code and offset travel alongside the RAM read
	always_ff @(posedge clk)
	begin
		if (load_go)
		begin
			op_q  <= bus.op;
			off_q <= byte_off;
		end
	end

	assign byte_sel = rword.b[off_q];
	assign half_sel = rword.h[off_q[1]];

	always_comb
	begin
		case (op_q)
			isa_pkg::op_byte:   load_data = {{24{byte_sel[7]}}, byte_sel};
			isa_pkg::op_half:   load_data = {{16{half_sel[15]}}, half_sel};
			isa_pkg::op_byte_u: load_data = {24'b0, byte_sel};
			isa_pkg::op_half_u: load_data = {16'b0, half_sel};
			default:            load_data = rword; // lw and unused codes
		endcase
	end

	assign bus.rdata  = load_data;
	assign bus.rvalid = valid_q;

endmodule

// File: lane_ram.sv
`timescale 1ns/10ps

module lane_ram (
	input  logic                        clk,
	input  logic [mem_pkg::dmem_aw-1:0] addr,
	input  logic                        rd,
	input  mem_pkg::lane_mask_t         lane_we,
	input  logic [31:0]                 wdata,
	output mem_pkg::mem_word_u          rword
);

	mem_pkg::mem_word_u mem [mem_pkg::dmem_words];

	// byte lane writes, lanes without enable keep their old byte
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (lane_we[i])
				mem[addr].b[i] <= wdata[i*8 +: 8];
		end
	end

	// registered read, output holds between reads
	always_ff @(posedge clk)
	begin
		if (rd)
			rword <= mem[addr];
	end

endmodule

// File: dmem_if.sv
`timescale 1ns/10ps

interface dmem_if;

	logic [isa_pkg::xlen-1:0] addr;  // byte address
	isa_pkg::mem_op_t         op;    // width code
	logic                     rd;    // load strobe
	logic                     we;    // store strobe
	logic [isa_pkg::xlen-1:0] wdata; // store data, low bits used
	logic [isa_pkg::xlen-1:0] rdata; // extended load data
	logic                     rvalid; // one cycle after rd

	// side that issues loads and stores
	modport core (
		output addr, op, rd, we, wdata,
		input  rdata, rvalid
	);

	// side that serves them
	modport memory (
		input  addr, op, rd, we, wdata,
		output rdata, rvalid
	);

endinterface

// File: mem_pkg.sv
package mem_pkg;

	// depth of the instruction memory in 32-bit words
	localparam int imem_words = 4096;

	// depth of the data memory in 32-bit words
	localparam int dmem_words = 4096;

	// word address widths, byte address bits 1:0 are dropped
	localparam int imem_aw = $clog2(imem_words); // 12 bits
	localparam int dmem_aw = $clog2(dmem_words); // 12 bits

	// one enable bit per byte lane, bit 0 is the lowest byte
	typedef logic [3:0] lane_mask_t;

	// A stored data word read two ways. Byte loads pick a lane with
	// address bits 1:0, halfword loads pick a half with address bit 1.
	typedef union packed {
		logic [3:0][7:0]  b; // byte lanes
		logic [1:0][15:0] h; // halfword lanes
	} mem_word_u;

endpackage

// File: isa_pkg.sv
package isa_pkg;

	// register and address width of the RV32I core
	localparam int xlen = 32;

	// every RV32I instruction is one 32-bit word
	localparam int ilen = 32;

	// load/store width code, straight from funct3 of the memory instruction
	typedef logic [2:0] mem_op_t;

	// The same funct3 code means the load width and the store width.
	// The unsigned codes exist for loads only.
	localparam mem_op_t op_byte   = 3'b000; // lb / sb
	localparam mem_op_t op_half   = 3'b001; // lh / sh
	localparam mem_op_t op_word   = 3'b010; // lw / sw
	localparam mem_op_t op_byte_u = 3'b100; // lbu
	localparam mem_op_t op_half_u = 3'b101; // lhu

	// marker word that ends a test program
	localparam logic [ilen-1:0] halt_word = 32'hdead10cc;

endpackage
